/* compile.f */
+incdir+source
source/nlc_ctrl_pkg.sv
source/nlc_data_pkg.sv
source/nlc_channel_bank.sv
source/nlc_mac_unit.sv
source/nlc_sequencer.sv
source/nlc_result_store.sv
source/nlc_top.sv
verif/nlc_asserts.sv
verif/nlc_tb.sv

/* source/nlc_channel_bank.sv */
`default_nettype none
`include "nlc_params.svh"

module nlc_channel_bank (
  input  logic                                     clk,
  input  logic                                     rst,
  input  logic                                     start,
  input  nlc_data_pkg::sample_t [`NLC_NUM_CH-1:0]  adc,
  input  nlc_data_pkg::ch_cfg_t [`NLC_NUM_CH-1:0]  cfg,
  input  nlc_data_pkg::ch_idx_t                    rd_ch,
  output nlc_data_pkg::word_t                      rd_sample,
  output nlc_data_pkg::ch_cfg_t                    rd_cfg,
  input  logic                                     busy
);
  import nlc_data_pkg::*;

  sample_t [`NLC_NUM_CH-1:0] adc_q;
  ch_cfg_t [`NLC_NUM_CH-1:0] cfg_q;
  sample_t                   sel_sample;

  // Snapshot of all channels, taken only when a run can start
  always_ff @(posedge clk) begin
    if (!rst && start && !busy) begin
      adc_q <= adc;
      cfg_q <= cfg;
    end
  end

  assign sel_sample = adc_q[rd_ch];

  // Sign extend, then move the integer part above the fraction bits
  assign rd_sample = word_t'(sel_sample) <<< `NLC_FRAC_BITS;

  assign rd_cfg = cfg_q[rd_ch];

endmodule

`default_nettype wire

/* source/nlc_ctrl_pkg.sv */
`default_nettype none

package nlc_ctrl_pkg;

  // Sequencer phases
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_NORM,
    ST_HORNER,
    ST_DRAIN
  } seq_state_t;

  // Multiply-add operations
  // MAC_ADD_MUL is (a + c) * b, used for normalization
  // MAC_MUL_ADD is a * b + c, one Horner step
  typedef enum logic {
    MAC_ADD_MUL,
    MAC_MUL_ADD
  } mac_op_t;

endpackage

`default_nettype wire

/* source/nlc_data_pkg.sv */
`default_nettype none
`include "nlc_params.svh"

package nlc_data_pkg;

  typedef logic signed [`NLC_SAMPLE_W-1:0] sample_t;
  typedef logic signed [`NLC_WORD_W-1:0]   word_t;
  typedef logic [`NLC_CH_IDX_W-1:0]        ch_idx_t;

  // Calibration set of one channel, coeff[k] belongs to power k
  typedef struct packed {
    word_t                  neg_mean;
    word_t                  recip_stdev;
    word_t [`NLC_ORDER:0]   coeff;
  } ch_cfg_t;

  // One operation into the multiply-add unit
  // ch and final_pass ride along as the write-back tag
  typedef struct packed {
    nlc_ctrl_pkg::mac_op_t op;
    word_t                 a;
    word_t                 b;
    word_t                 c;
    ch_idx_t               ch;
    logic                  final_pass;
  } mac_req_t;

  typedef struct packed {
    word_t   result;
    ch_idx_t ch;
    logic    final_pass;
  } mac_rsp_t;

endpackage

`default_nettype wire

/* source/nlc_mac_unit.sv */
`default_nettype none
`include "nlc_params.svh"

module nlc_mac_unit (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   req_valid,
  input  nlc_data_pkg::mac_req_t req,
  output logic                   rsp_valid,
  output nlc_data_pkg::mac_rsp_t rsp
);
  import nlc_data_pkg::*;
  import nlc_ctrl_pkg::*;

  localparam int PROD_W = 2 * `NLC_WORD_W;

  word_t                    pre_sum;
  logic signed [PROD_W-1:0] prod_d;
  logic signed [PROD_W-1:0] prod_q;
  word_t                    addend_q;
  ch_idx_t                  ch_q;
  logic                     final_q;
  logic                     valid_q;
  word_t                    prod_scaled;

  // Stage one, pre-add only for normalization
  always_comb begin
    pre_sum = (req.op == MAC_ADD_MUL) ? word_t'(req.a + req.c) : req.a;
    prod_d  = pre_sum * req.b;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= req_valid;
    end
  end

  always_ff @(posedge clk) begin
    prod_q   <= prod_d;
    addend_q <= (req.op == MAC_MUL_ADD) ? req.c : '0;
    ch_q     <= req.ch;
    final_q  <= req.final_pass;
  end

  // Stage two, rescale the product and wrap the sum to word width
  assign prod_scaled = word_t'(prod_q >>> `NLC_FRAC_BITS);

  always_ff @(posedge clk) begin
    if (rst) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= valid_q;
    end
  end

  always_ff @(posedge clk) begin
    rsp.result     <= prod_scaled + addend_q;
    rsp.ch         <= ch_q;
    rsp.final_pass <= final_q;
  end

endmodule

`default_nettype wire

/* source/nlc_params.svh */
`ifndef NLC_PARAMS_SVH
`define NLC_PARAMS_SVH

// Channels handled per run
`define NLC_NUM_CH 16

// ADC sample and corrected output width
`define NLC_SAMPLE_W 21

// Fixed-point word, fraction bits included
`define NLC_WORD_W 32
`define NLC_FRAC_BITS 10

// Polynomial order, so ORDER+1 coefficients
`define NLC_ORDER 5

// Request to response, in cycles
`define NLC_MAC_LATENCY 2

`define NLC_CH_IDX_W 4

`endif

/* source/nlc_result_store.sv */
`default_nettype none
`include "nlc_params.svh"

module nlc_result_store (
  input  logic                                     clk,
  input  logic                                     rst,
  input  logic                                     rsp_valid,
  input  nlc_data_pkg::mac_rsp_t                   rsp,
  output nlc_data_pkg::sample_t [`NLC_NUM_CH-1:0]  x_lin,
  output logic                                     done,
  output logic                                     run_done
);
  import nlc_data_pkg::*;

  localparam sample_t SAT_MAX = {1'b0, {(`NLC_SAMPLE_W-1){1'b1}}};
  localparam sample_t SAT_MIN = {1'b1, {(`NLC_SAMPLE_W-1){1'b0}}};
  localparam ch_idx_t LAST_CH = ch_idx_t'(`NLC_NUM_CH - 1);

  word_t   scaled;
  sample_t sat_val;
  logic    last_wr;

  // Back to integer sample units, clamp to the ADC range
  always_comb begin
    scaled = rsp.result >>> `NLC_FRAC_BITS;
    if (scaled > SAT_MAX) begin
      sat_val = SAT_MAX;
    end else if (scaled < SAT_MIN) begin
      sat_val = SAT_MIN;
    end else begin
      sat_val = sample_t'(scaled);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      x_lin   <= '0;
      last_wr <= 1'b0;
      done    <= 1'b0;
    end else begin
      if (rsp_valid && rsp.final_pass) begin
        x_lin[rsp.ch] <= sat_val;
      end
      last_wr <= rsp_valid && rsp.final_pass && (rsp.ch == LAST_CH);
      // One cycle after the top channel lands
      done    <= last_wr;
    end
  end

  assign run_done = done;

endmodule

`default_nettype wire

/* source/nlc_sequencer.sv */
`default_nettype none
`include "nlc_params.svh"

module nlc_sequencer (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   start,
  output logic                   busy,
  output nlc_data_pkg::ch_idx_t  rd_ch,
  input  nlc_data_pkg::word_t    rd_sample,
  input  nlc_data_pkg::ch_cfg_t  rd_cfg,
  output logic                   req_valid,
  output nlc_data_pkg::mac_req_t req,
  input  logic                   rsp_valid,
  input  nlc_data_pkg::mac_rsp_t rsp,
  input  logic                   run_done
);
  import nlc_data_pkg::*;
  import nlc_ctrl_pkg::*;

  localparam int      PASS_W  = $clog2(`NLC_ORDER + 1);
  localparam ch_idx_t LAST_CH = ch_idx_t'(`NLC_NUM_CH - 1);

  seq_state_t        state;
  ch_idx_t           ch_cnt;
  logic [PASS_W-1:0] pass_cnt;
  logic              wb_to_norm;

  word_t norm_q [`NLC_NUM_CH];
  word_t acc_q  [`NLC_NUM_CH];

  // A channel's result must be back before the next pass reads it
  if (`NLC_NUM_CH < `NLC_MAC_LATENCY + 1) begin : g_latency_check
    $error("channel count too small for the multiply-add latency");
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= ST_IDLE;
      busy     <= 1'b0;
      ch_cnt   <= '0;
      pass_cnt <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (start) begin
            state    <= ST_NORM;
            busy     <= 1'b1;
            ch_cnt   <= '0;
            pass_cnt <= '0;
          end
        end
        ST_NORM: begin
          ch_cnt <= ch_cnt + 1'b1;
          if (ch_cnt == LAST_CH) begin
            state    <= ST_HORNER;
            ch_cnt   <= '0;
            pass_cnt <= PASS_W'(1);
          end
        end
        ST_HORNER: begin
          ch_cnt <= ch_cnt + 1'b1;
          if (ch_cnt == LAST_CH) begin
            ch_cnt <= '0;
            if (pass_cnt == PASS_W'(`NLC_ORDER)) begin
              state <= ST_DRAIN;
            end else begin
              pass_cnt <= pass_cnt + 1'b1;
            end
          end
        end
        ST_DRAIN: begin
          // Last results still in flight
          if (run_done) begin
            state <= ST_IDLE;
            busy  <= 1'b0;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Responses come back in issue order, first full sweep is normalization
  always_ff @(posedge clk) begin
    if (rst) begin
      wb_to_norm <= 1'b0;
    end else if (state == ST_IDLE && start) begin
      wb_to_norm <= 1'b1;
    end else if (rsp_valid && rsp.ch == LAST_CH) begin
      wb_to_norm <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rsp_valid) begin
      if (wb_to_norm) begin
        norm_q[rsp.ch] <= rsp.result;
      end else begin
        acc_q[rsp.ch] <= rsp.result;
      end
    end
  end

  assign rd_ch     = ch_cnt;
  assign req_valid = (state == ST_NORM) || (state == ST_HORNER);

  always_comb begin
    req    = '0;
    req.ch = ch_cnt;
    if (state == ST_NORM) begin
      req.op = MAC_ADD_MUL;
      req.a  = rd_sample;
      req.b  = rd_cfg.recip_stdev;
      req.c  = rd_cfg.neg_mean;
    end else if (state == ST_HORNER) begin
      req.op = MAC_MUL_ADD;
      // First Horner step starts from the top coefficient
      req.a  = (pass_cnt == PASS_W'(1)) ? rd_cfg.coeff[`NLC_ORDER] : acc_q[ch_cnt];
      req.b  = norm_q[ch_cnt];
      req.c  = rd_cfg.coeff[`NLC_ORDER - pass_cnt];
      req.final_pass = (pass_cnt == PASS_W'(`NLC_ORDER));
    end
  end

endmodule

`default_nettype wire

/* source/nlc_top.sv */
`default_nettype none
`include "nlc_params.svh"

module nlc_top (
  input  logic                                     clk,
  input  logic                                     rst,
  input  logic                                     start,
  input  nlc_data_pkg::sample_t [`NLC_NUM_CH-1:0]  adc,
  input  nlc_data_pkg::ch_cfg_t [`NLC_NUM_CH-1:0]  cfg,
  output nlc_data_pkg::sample_t [`NLC_NUM_CH-1:0]  x_lin,
  output logic                                     busy,
  output logic                                     done
);
  import nlc_data_pkg::*;

  ch_idx_t  rd_ch;
  word_t    rd_sample;
  ch_cfg_t  rd_cfg;
  logic     req_valid;
  mac_req_t req;
  logic     rsp_valid;
  mac_rsp_t rsp;
  logic     run_done;

  nlc_channel_bank u_bank (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .adc       (adc),
    .cfg       (cfg),
    .rd_ch     (rd_ch),
    .rd_sample (rd_sample),
    .rd_cfg    (rd_cfg),
    .busy      (busy)
  );

  nlc_sequencer u_seq (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .busy      (busy),
    .rd_ch     (rd_ch),
    .rd_sample (rd_sample),
    .rd_cfg    (rd_cfg),
    .req_valid (req_valid),
    .req       (req),
    .rsp_valid (rsp_valid),
    .rsp       (rsp),
    .run_done  (run_done)
  );

  nlc_mac_unit u_mac (
    .clk       (clk),
    .rst       (rst),
    .req_valid (req_valid),
    .req       (req),
    .rsp_valid (rsp_valid),
    .rsp       (rsp)
  );

  // Final pass responses only
  nlc_result_store u_store (
    .clk       (clk),
    .rst       (rst),
    .rsp_valid (rsp_valid),
    .rsp       (rsp),
    .x_lin     (x_lin),
    .done      (done),
    .run_done  (run_done)
  );

endmodule

`default_nettype wire

/* verif/nlc_asserts.sv */
`default_nettype none
`include "nlc_params.svh"

module nlc_asserts (
  input logic clk,
  input logic rst,
  input logic start,
  input logic busy,
  input logic done
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int RUN_LAT = (`NLC_ORDER + 1) * `NLC_NUM_CH + `NLC_MAC_LATENCY + 2;

  logic start_taken;
  int   assert_failures = 0;

  // Start only counts while idle
  assign start_taken = start && !busy;

  done_one_cycle: assert property (@(posedge clk) disable iff (rst) done |=> !done)
    else begin
      assert_failures++;
      $error("done stayed high for more than one cycle");
    end

  done_while_busy: assert property (@(posedge clk) disable iff (rst) done |-> busy)
    else begin
      assert_failures++;
      $error("done pulsed while not busy");
    end

  idle_after_reset: assert property (@(posedge clk) rst |=> !busy)
    else begin
      assert_failures++;
      $error("busy high in the cycle after reset");
    end

  done_latency: assert property (@(posedge clk) disable iff (rst)
    start_taken |-> ##RUN_LAT done)
    else begin
      assert_failures++;
      $error("done missing at the expected latency after start");
    end

endmodule

bind nlc_top nlc_asserts u_asserts (
  .clk   (clk),
  .rst   (rst),
  .start (start),
  .busy  (busy),
  .done  (done)
);

`default_nettype wire

/* verif/nlc_tb.sv */
`default_nettype none
`include "nlc_params.svh"

module nlc_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import nlc_data_pkg::*;

  localparam int RUN_LAT = (`NLC_ORDER + 1) * `NLC_NUM_CH + `NLC_MAC_LATENCY + 2;
  localparam int RESET_CYCLES = 10;
  localparam int TIMEOUT_CYCLES = 10 * (RUN_LAT + 4) + RESET_CYCLES;
  localparam sample_t SAMPLE_MAX = {1'b0, {(`NLC_SAMPLE_W-1){1'b1}}};
  localparam sample_t SAMPLE_MIN = {1'b1, {(`NLC_SAMPLE_W-1){1'b0}}};

  logic                      clk;
  logic                      rst;
  logic                      start;
  sample_t [`NLC_NUM_CH-1:0] adc;
  ch_cfg_t [`NLC_NUM_CH-1:0] cfg;
  sample_t [`NLC_NUM_CH-1:0] x_lin;
  logic                      busy;
  logic                      done;

  sample_t [`NLC_NUM_CH-1:0] expected;
  logic [31:0]               rng_state = 32'd78;
  int                        sample_errors = 0;
  int                        flag_errors = 0;
  int                        assert_errors = 0;

  nlc_top DUT (
    .clk   (clk),
    .rst   (rst),
    .start (start),
    .adc   (adc),
    .cfg   (cfg),
    .x_lin (x_lin),
    .busy  (busy),
    .done  (done)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Simulation failed");
    $finish;
  end

  function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // Product rescaled by the fraction bits and wrapped to a word
  function automatic word_t fixed_mul(word_t a, word_t b);
    longint p;
    p = longint'(a) * longint'(b);
    return word_t'(p >>> `NLC_FRAC_BITS);
  endfunction

  function automatic sample_t correct_sample(sample_t s, ch_cfg_t c);
    word_t  x;
    word_t  norm;
    word_t  acc;
    longint scaled;
    int     k;
    x = s;
    x = x <<< `NLC_FRAC_BITS;
    norm = fixed_mul(word_t'(x + c.neg_mean), c.recip_stdev);
    acc = word_t'(fixed_mul(c.coeff[`NLC_ORDER], norm) + c.coeff[`NLC_ORDER-1]);
    for (k = `NLC_ORDER - 2; k >= 0; k--) begin
      acc = word_t'(fixed_mul(acc, norm) + c.coeff[k]);
    end
    scaled = longint'(acc) >>> `NLC_FRAC_BITS;
    if (scaled > longint'(SAMPLE_MAX)) return SAMPLE_MAX;
    if (scaled < longint'(SAMPLE_MIN)) return SAMPLE_MIN;
    return sample_t'(scaled);
  endfunction

  task automatic check_sample(input sample_t got, input sample_t exp, input string what);
    if (got !== exp) begin
      sample_errors++;
      $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      flag_errors++;
      $display("CHECK FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  // Small ranges so the fifth power stays inside a word
  task automatic randomize_inputs();
    logic [31:0] r;
    word_t       w;
    int          ch;
    int          k;
    for (ch = 0; ch < `NLC_NUM_CH; ch++) begin
      r = xorshift32();
      adc[ch] = $signed(r[10:0]);
      w = $signed(r[20:11]);
      cfg[ch].neg_mean = w <<< `NLC_FRAC_BITS;
      cfg[ch].recip_stdev = 32'd1 + r[22:21];
      for (k = 0; k <= `NLC_ORDER; k++) begin
        r = xorshift32();
        w = $signed(r[13:0]);
        cfg[ch].coeff[k] = w;
      end
    end
  endtask

  task automatic model_expected();
    int ch;
    for (ch = 0; ch < `NLC_NUM_CH; ch++) begin
      expected[ch] = correct_sample(adc[ch], cfg[ch]);
    end
  endtask

  task automatic compare_x_lin(input string tag);
    int ch;
    for (ch = 0; ch < `NLC_NUM_CH; ch++) begin
      check_sample(x_lin[ch], expected[ch], $sformatf("%s x_lin[%0d]", tag, ch));
    end
  endtask

  // Start one run and expect done exactly RUN_LAT cycles later
  // restart_at > 0 loads new inputs and pulses start again mid-run
  task automatic launch_run(input string tag, input int restart_at);
    int n;
    start = 1'b1;
    tick();
    start = 1'b0;
    for (n = 1; n <= RUN_LAT; n++) begin
      // Values seen here are what edge n samples
      if (n == 1) check_flag(busy, 1'b1, {tag, " busy"});
      check_flag(done, n == RUN_LAT, $sformatf("%s done at cycle %0d", tag, n));
      if (n == restart_at) begin
        randomize_inputs();
        start = 1'b1;
      end else begin
        start = 1'b0;
      end
      tick();
    end
  endtask

  task automatic reset_values();
    int ch;
    check_flag(busy, 1'b0, "busy after reset");
    check_flag(done, 1'b0, "done after reset");
    for (ch = 0; ch < `NLC_NUM_CH; ch++) begin
      check_sample(x_lin[ch], '0, $sformatf("reset x_lin[%0d]", ch));
    end
  endtask

  task automatic identity_passthrough();
    int ch;
    for (ch = 0; ch < `NLC_NUM_CH; ch++) begin
      adc[ch] = sample_t'(xorshift32());
      cfg[ch] = '0;
      cfg[ch].recip_stdev = word_t'(1) <<< `NLC_FRAC_BITS;
      cfg[ch].coeff[1] = word_t'(1) <<< `NLC_FRAC_BITS;
      expected[ch] = adc[ch];
    end
    adc[0] = SAMPLE_MAX;
    expected[0] = SAMPLE_MAX;
    adc[1] = SAMPLE_MIN;
    expected[1] = SAMPLE_MIN;
    launch_run("identity", 0);
    compare_x_lin("identity");
  endtask

  task automatic random_against_model();
    int i;
    for (i = 0; i < 2; i++) begin
      randomize_inputs();
      model_expected();
      launch_run($sformatf("random %0d", i), 0);
      compare_x_lin($sformatf("random %0d", i));
    end
  endtask

  // Constant term alone and far outside the sample range
  task automatic saturation_limits();
    int ch;
    for (ch = 0; ch < `NLC_NUM_CH; ch++) begin
      adc[ch] = sample_t'(ch * 37);
      cfg[ch] = '0;
      cfg[ch].recip_stdev = word_t'(1) <<< `NLC_FRAC_BITS;
      cfg[ch].coeff[0] = ch[0] ? 32'hA000_0000 : 32'h4000_0000;
      expected[ch] = ch[0] ? SAMPLE_MIN : SAMPLE_MAX;
    end
    launch_run("saturation", 0);
    compare_x_lin("saturation");
  endtask

  task automatic restart_ignored();
    int n;
    randomize_inputs();
    model_expected();
    launch_run("restart", 5);
    compare_x_lin("restart first inputs");
    for (n = 0; n < 20; n++) begin
      tick();
      check_flag(done, 1'b0, "extra done after ignored start");
    end
    check_flag(busy, 1'b0, "busy after run");
    // Inputs loaded mid-run are still on the bus
    model_expected();
    launch_run("rerun", 0);
    compare_x_lin("rerun");
  endtask

  initial begin
    rst = 1'b1;
    start = 1'b0;
    adc = '0;
    cfg = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;
    reset_values();
    identity_passthrough();
    random_against_model();
    saturation_limits();
    restart_ignored();
    tick();
    assert_errors = DUT.u_asserts.assert_failures;
    $display("Errors: %0d sample, %0d flag, %0d assertion",
             sample_errors, flag_errors, assert_errors);
    if (sample_errors + flag_errors + assert_errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
